/* frame_sequencer.sv */
`timescale 1ns/1ns
`include "pcm2dsd_consts.svh"

module frame_sequencer (
    input  logic                      bck,
    input  logic                      reset_n,
    input  pcm2dsd_pkg::ctrl_t        ctrl_i,
    input  pcm2dsd_pkg::sample_pair_t pair_i,
    input  logic                      pair_valid_i,
    output pcm2dsd_pkg::line_bits_t   bits_o,
    output logic                      active_o
);

    import pcm2dsd_pkg::*;

    localparam int SLOT_W = `SLOT_CNT_W;
    localparam int BIT_W  = $clog2(`PCM_SAMPLE_W);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PCM_FRAME_SLOTS - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`PCM_SAMPLE_W - 1);

    sample_pair_t      buf_q;
    logic [SLOT_W-1:0] slot_q;
    logic              active_q;
    logic              locked_q;
    logic              dsd_mode_q;
    logic [SLOT_W-1:0] pcm_idx;
    logic [BIT_W-1:0]  dsd_idx;

    // mode is taken from the first frame of a run and kept until run drops
    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            locked_q   <= 1'b0;
            dsd_mode_q <= 1'b0;
        end else if (!ctrl_i.run) begin
            locked_q   <= 1'b0;
            dsd_mode_q <= 1'b0;
        end else if (pair_valid_i && !locked_q) begin
            locked_q   <= 1'b1;
            dsd_mode_q <= ctrl_i.use_dsd;
        end
    end

    // a strobe in slot 63 restarts at slot 0 with no idle cycle
    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            active_q <= 1'b0;
            slot_q   <= '0;
        end else if (!ctrl_i.run) begin
            active_q <= 1'b0;
            slot_q   <= '0;
        end else if (pair_valid_i) begin
            active_q <= 1'b1;
            slot_q   <= '0;
        end else if (active_q) begin
            slot_q <= slot_q + 1'b1;
            if (slot_q == LAST_SLOT) begin
                active_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            buf_q <= '0;
        end else if (pair_valid_i) begin
            buf_q <= pair_i;
        end
    end

    // PCM sends left then right MSB first, DSD sends one bit per two slots
    assign pcm_idx = LAST_SLOT - slot_q;
    assign dsd_idx = LAST_BIT - slot_q[SLOT_W-1:1];

    always_comb begin
        if (dsd_mode_q) begin
            bits_o.clk_line = slot_q[0];
            bits_o.line_a   = buf_q.left[dsd_idx];
            bits_o.line_b   = buf_q.right[dsd_idx];
        end else begin
            bits_o.clk_line = 1'b0;
            bits_o.line_a   = slot_q[SLOT_W-1];
            bits_o.line_b   = buf_q[pcm_idx];
        end
    end

    assign active_o = active_q;

    // the capture side must stay frame-aligned with the output side
    assert property (@(posedge bck) disable iff (!reset_n)
        (pair_valid_i && active_o) |-> (slot_q == LAST_SLOT));

endmodule

/* i2s_frame_rx.sv */
`timescale 1ns/1ns
`include "pcm2dsd_consts.svh"

module i2s_frame_rx (
    input  logic                      bck,
    input  logic                      reset_n,
    input  pcm2dsd_pkg::ctrl_t        ctrl_i,
    input  logic                      lrck_i,
    input  logic                      sdata_i,
    output pcm2dsd_pkg::sample_pair_t pair_o,
    output logic                      pair_valid_o
);

    localparam int SLOT_W = `SLOT_CNT_W;
    localparam logic [SLOT_W-1:0] LAST_LEFT = SLOT_W'(`PCM_SAMPLE_W - 1);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PCM_FRAME_SLOTS - 1);

    typedef enum logic {
        RX_IDLE,
        RX_WORK
    } rx_state_e;

    rx_state_e                state_q;
    logic [SLOT_W-1:0]        slot_q;
    logic                     lrck_q;
    logic                     lrck_q2;
    logic                     sdata_q;
    logic                     lrck_fall;
    logic                     capture_en;
    logic [`PCM_SAMPLE_W-1:0] shift_q;
    logic [`PCM_SAMPLE_W-1:0] shift_d;
    logic [`PCM_SAMPLE_W-1:0] left_q;

    // sdata is delayed along with lrck, so the bit sampled with the first
    // low lrck is the one shifted in when the fall is detected
    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            lrck_q  <= 1'b0;
            lrck_q2 <= 1'b0;
            sdata_q <= 1'b0;
        end else begin
            lrck_q  <= lrck_i;
            lrck_q2 <= lrck_q;
            sdata_q <= sdata_i;
        end
    end

    assign lrck_fall  = lrck_q2 & ~lrck_q;
    assign shift_d    = {shift_q[`PCM_SAMPLE_W-2:0], sdata_q};
    assign capture_en = ctrl_i.run && (state_q == RX_WORK);

    // sync once on the first left frame, then free-run every 64 slots
    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            state_q      <= RX_IDLE;
            slot_q       <= '0;
            pair_valid_o <= 1'b0;
        end else if (!ctrl_i.run) begin
            state_q      <= RX_IDLE;
            slot_q       <= '0;
            pair_valid_o <= 1'b0;
        end else begin
            pair_valid_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    // left MSB goes in on this edge
                    if (lrck_fall) begin
                        state_q <= RX_WORK;
                        slot_q  <= SLOT_W'(1);
                    end
                end
                RX_WORK: begin
                    slot_q       <= slot_q + 1'b1;
                    pair_valid_o <= (slot_q == LAST_SLOT);
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '0;
            left_q  <= '0;
            pair_o  <= '0;
        end else begin
            shift_q <= shift_d;
            if (capture_en && slot_q == LAST_LEFT) begin
                left_q <= shift_d;
            end
            if (capture_en && slot_q == LAST_SLOT) begin
                pair_o <= '{left: left_q, right: shift_d};
            end
        end
    end

    // one strobe per frame, also across a stop and a new sync
    assert property (@(posedge bck) disable iff (!reset_n)
        pair_valid_o |=> !pair_valid_o [*(`PCM_FRAME_SLOTS - 1)]);

endmodule

/* line_driver.sv */
`timescale 1ns/1ns

module line_driver (
    input  logic                    bck,
    input  logic                    reset_n,
    input  pcm2dsd_pkg::line_bits_t bits_i,
    input  logic                    active_i,
    output logic                    clk_line_o,
    output logic                    line_a_o,
    output logic                    line_b_o
);

    import pcm2dsd_pkg::*;

    line_bits_t lines_q;

    // pins come straight from flops, all low between frames
    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            lines_q <= '0;
        end else if (active_i) begin
            lines_q <= bits_i;
        end else begin
            lines_q <= '0;
        end
    end

    assign clk_line_o = lines_q.clk_line;
    assign line_a_o   = lines_q.line_a;
    assign line_b_o   = lines_q.line_b;

    // the DSD clock is high for one cycle at a time, also at frame ends and stops
    assert property (@(posedge bck) disable iff (!reset_n)
        clk_line_o |=> !clk_line_o);

endmodule

/* pcm2dsd_consts.svh */
`ifndef PCM2DSD_CONSTS_SVH
`define PCM2DSD_CONSTS_SVH

// bits per channel word, MSB first on the wire
`define PCM_SAMPLE_W     32

// bck cycles in one I2S frame, left word then right word
`define PCM_FRAME_SLOTS  64

// counts 0 to PCM_FRAME_SLOTS-1
`define SLOT_CNT_W       6

// control byte layout
`define CTRL_W           8
// high runs the capture and output path
`define CTRL_RUN_BIT     7
// high asks for DSD output, latched at the start of a run
`define CTRL_DSD_BIT     6

`endif

/* pcm2dsd_pkg.sv */
`include "pcm2dsd_consts.svh"

package pcm2dsd_pkg;

    // decoded control byte
    typedef struct packed {
        // low stops both capture and output
        logic run;
        logic use_dsd;
    } ctrl_t;

    // one captured I2S frame, left word in the upper half
    typedef struct packed {
        logic [`PCM_SAMPLE_W-1:0] left;
        logic [`PCM_SAMPLE_W-1:0] right;
    } sample_pair_t;

    // one bck cycle of output line values
    typedef struct packed {
        // DSD clock, held low in PCM mode
        logic clk_line;
        // lrck in PCM mode, left DSD bit in DSD mode
        logic line_a;
        // serial data in PCM mode, right DSD bit in DSD mode
        logic line_b;
    } line_bits_t;

endpackage

/* pcm2dsd_top.sv */
`timescale 1ns/1ns
`include "pcm2dsd_consts.svh"

module pcm2dsd_top (
    input  logic              bck,
    input  logic              reset_n,
    input  logic [`CTRL_W-1:0] ctrl_i,
    input  logic              lrck_i,
    input  logic              sdata_i,
    output logic              clk_line_o,
    output logic              line_a_o,
    output logic              line_b_o
);

    import pcm2dsd_pkg::*;

    ctrl_t        ctrl;
    sample_pair_t pair;
    logic         pair_valid;
    line_bits_t   bits;
    logic         active;

    // only the run and dsd bits of the control byte are used
    assign ctrl.run     = ctrl_i[`CTRL_RUN_BIT];
    assign ctrl.use_dsd = ctrl_i[`CTRL_DSD_BIT];

    i2s_frame_rx u_i2s_frame_rx (
        .bck          (bck),
        .reset_n      (reset_n),
        .ctrl_i       (ctrl),
        .lrck_i       (lrck_i),
        .sdata_i      (sdata_i),
        .pair_o       (pair),
        .pair_valid_o (pair_valid)
    );

    frame_sequencer u_frame_sequencer (
        .bck          (bck),
        .reset_n      (reset_n),
        .ctrl_i       (ctrl),
        .pair_i       (pair),
        .pair_valid_i (pair_valid),
        .bits_o       (bits),
        .active_o     (active)
    );

    line_driver u_line_driver (
        .bck        (bck),
        .reset_n    (reset_n),
        .bits_i     (bits),
        .active_i   (active),
        .clk_line_o (clk_line_o),
        .line_a_o   (line_a_o),
        .line_b_o   (line_b_o)
    );

endmodule

/* project.f */
+incdir+.
pcm2dsd_pkg.sv
i2s_frame_rx.sv
frame_sequencer.sv
line_driver.sv
pcm2dsd_top.sv
tb_pcm2dsd.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pcm2dsd -f project.f -o sim_pcm2dsd

./obj_dir/sim_pcm2dsd | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

/* tb_pcm2dsd.sv */
`timescale 1ns/1ns
`include "pcm2dsd_consts.svh"

module tb_pcm2dsd;

    import pcm2dsd_pkg::*;

    localparam int N_RAND_FRAMES = 20;
    localparam int N_LOCK_FRAMES = 6;
    localparam int N_STOP_FRAMES = 3;
    localparam int N_RESTART     = 4;
    localparam int IDLE_CYCLES   = 200;
    localparam int CUT_SLOT      = 20;
    // left MSB driven on a falling edge shows on the pins 67 falling edges later
    // (64 bit samples, strobe, buffer load, pin register)
    localparam int OUT_LATENCY   = 67;
    // sent frames, one cut frame, and about three frames of lead and drain per run
    localparam int TOTAL_FRAMES  = 2 * N_RAND_FRAMES + N_LOCK_FRAMES + N_STOP_FRAMES + 1
                                   + N_RESTART + 3 * 5 + IDLE_CYCLES / 64;
    localparam int TIMEOUT_CYCLES = (TOTAL_FRAMES + 4) * 64 + 100;

    logic               bck = 1'b0;
    logic               reset_n;
    logic [`CTRL_W-1:0] ctrl_i;
    logic               lrck_i;
    logic               sdata_i;
    logic               clk_line_o;
    logic               line_a_o;
    logic               line_b_o;
    line_bits_t         pins;

    logic [31:0]  rng_state;
    int           cycle_cnt = 0;
    int           pair_errs = 0;
    int           line_errs = 0;
    int           frames_checked = 0;

    // reference model, one entry per pair that must come out whole
    sample_pair_t exp_pair_q[$];
    int           exp_start_q[$];
    logic         exp_dsd_q[$];

    logic         mon_busy = 1'b0;
    logic         mon_dsd = 1'b0;
    int           mon_slot = 0;
    sample_pair_t mon_pair;

    pcm2dsd_top u_pcm2dsd_top (
        .bck        (bck),
        .reset_n    (reset_n),
        .ctrl_i     (ctrl_i),
        .lrck_i     (lrck_i),
        .sdata_i    (sdata_i),
        .clk_line_o (clk_line_o),
        .line_a_o   (line_a_o),
        .line_b_o   (line_b_o)
    );

    assign pins = '{clk_line: clk_line_o, line_a: line_a_o, line_b: line_b_o};

    initial begin
        forever #20 bck = ~bck;
    end

    always @(posedge bck) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_pair(input int idx, input sample_pair_t got, input sample_pair_t exp);
        if (got.left !== exp.left) begin
            pair_errs++;
            $display("mismatch pair.left in frame %0d: got 0x%08h, expected 0x%08h",
                     idx, got.left, exp.left);
        end
        if (got.right !== exp.right) begin
            pair_errs++;
            $display("mismatch pair.right in frame %0d: got 0x%08h, expected 0x%08h",
                     idx, got.right, exp.right);
        end
    endtask

    // only the lines selected by mask are compared
    task automatic check_lines(input string what, input line_bits_t got,
                               input line_bits_t exp, input line_bits_t mask);
        if (((got ^ exp) & mask) !== '0) begin
            line_errs++;
            $display("mismatch {clk_line,line_a,line_b} (%s) at cycle %0d: got 0x%h, expected 0x%h",
                     what, cycle_cnt, got, exp);
        end
    endtask

    // rebuilds words from the pins, sampled on the falling edge where they are stable
    always @(negedge bck) begin
        line_bits_t exp_fmt;
        line_bits_t fmt_mask;
        if (!mon_busy && exp_start_q.size() > 0 && cycle_cnt == exp_start_q[0]) begin
            mon_busy = 1'b1;
            mon_slot = 0;
            mon_dsd  = exp_dsd_q[0];
            mon_pair = '0;
        end
        if (mon_busy) begin
            if (mon_dsd) begin
                exp_fmt  = '{clk_line: mon_slot[0], line_a: 1'b0, line_b: 1'b0};
                fmt_mask = '{clk_line: 1'b1, line_a: 1'b0, line_b: 1'b0};
                if (clk_line_o) begin
                    mon_pair.left  = {mon_pair.left[`PCM_SAMPLE_W-2:0], line_a_o};
                    mon_pair.right = {mon_pair.right[`PCM_SAMPLE_W-2:0], line_b_o};
                end
            end else begin
                exp_fmt  = '{clk_line: 1'b0, line_a: (mon_slot >= `PCM_SAMPLE_W), line_b: 1'b0};
                fmt_mask = '{clk_line: 1'b1, line_a: 1'b1, line_b: 1'b0};
                if (!line_a_o) begin
                    mon_pair.left = {mon_pair.left[`PCM_SAMPLE_W-2:0], line_b_o};
                end else begin
                    mon_pair.right = {mon_pair.right[`PCM_SAMPLE_W-2:0], line_b_o};
                end
            end
            check_lines(mon_dsd ? "dsd frame" : "pcm frame", pins, exp_fmt, fmt_mask);
            mon_slot++;
            if (mon_slot == `PCM_FRAME_SLOTS) begin
                check_pair(frames_checked, mon_pair, exp_pair_q.pop_front());
                void'(exp_start_q.pop_front());
                void'(exp_dsd_q.pop_front());
                frames_checked++;
                mon_busy = 1'b0;
            end
        end
    end

    // run stays low, everything else toggles at random
    task automatic check_idle(input int n_cycles, input string what);
        logic [31:0] r;
        for (int i = 0; i < n_cycles; i++) begin
            check_lines(what, pins, '0, '1);
            r       = next_random();
            lrck_i  = r[0];
            sdata_i = r[1];
            ctrl_i  = r[15:8];
            ctrl_i[`CTRL_RUN_BIT] = 1'b0;
            @(negedge bck);
        end
    endtask

    // lrck settles high first so no stale falling edge is seen
    task automatic start_run(input logic dsd);
        @(negedge bck);
        lrck_i  = 1'b1;
        sdata_i = 1'b0;
        repeat (3) @(negedge bck);
        ctrl_i = '0;
        ctrl_i[`CTRL_RUN_BIT] = 1'b1;
        ctrl_i[`CTRL_DSD_BIT] = dsd;
    endtask

    task automatic stop_run(input int n_idle, input string what);
        @(negedge bck);
        ctrl_i[`CTRL_RUN_BIT] = 1'b0;
        lrck_i = 1'b1;
        // pins hold one more slot, then go low
        @(negedge bck);
        @(negedge bck);
        check_idle(n_idle, what);
    endtask

    task automatic wait_output_done();
        while (exp_pair_q.size() != 0) begin
            @(posedge bck);
        end
    endtask

    // left-justified I2S, lrck falls together with the left MSB
    task automatic send_frame(input sample_pair_t pair, input logic expect_out,
                              input logic dsd, input logic flip_dsd, input int n_slots);
        logic [2*`PCM_SAMPLE_W-1:0] bits;
        bits = pair;
        for (int s = 0; s < n_slots; s++) begin
            @(negedge bck);
            if (s == 0 && expect_out) begin
                exp_pair_q.push_back(pair);
                exp_start_q.push_back(cycle_cnt + OUT_LATENCY);
                exp_dsd_q.push_back(dsd);
            end
            if (s == 16 && flip_dsd) begin
                ctrl_i[`CTRL_DSD_BIT] = ~ctrl_i[`CTRL_DSD_BIT];
            end
            lrck_i  = (s >= `PCM_SAMPLE_W);
            sdata_i = bits[`PCM_FRAME_SLOTS-1-s];
        end
    endtask

    task automatic run_frames(input int n, input logic dsd, input logic flip_dsd);
        sample_pair_t p;
        start_run(dsd);
        for (int k = 0; k < n; k++) begin
            p.left  = next_random();
            p.right = next_random();
            // the mode is latched at the first strobe, so frame 0 keeps bit 6 steady
            send_frame(p, 1'b1, dsd, flip_dsd && (k > 0), `PCM_FRAME_SLOTS);
        end
        wait_output_done();
        stop_run(8, "run low after frames");
    endtask

    initial begin
        sample_pair_t p;
        reset_n   = 1'b0;
        ctrl_i    = '0;
        lrck_i    = 1'b1;
        sdata_i   = 1'b0;
        rng_state = 32'h2aa3;
        repeat (8) @(negedge bck);
        reset_n = 1'b1;

        check_idle(IDLE_CYCLES, "run low after reset");
        run_frames(N_RAND_FRAMES, 1'b0, 1'b0);
        // bit 6 flips during a PCM run and must be ignored
        run_frames(N_LOCK_FRAMES, 1'b0, 1'b1);
        run_frames(N_RAND_FRAMES, 1'b1, 1'b0);

        // the last full frame and the cut one are still in flight when run drops
        start_run(1'b0);
        for (int k = 0; k < N_STOP_FRAMES; k++) begin
            p.left  = next_random();
            p.right = next_random();
            send_frame(p, k < N_STOP_FRAMES - 1, 1'b0, 1'b0, `PCM_FRAME_SLOTS);
        end
        p.left  = next_random();
        p.right = next_random();
        send_frame(p, 1'b0, 1'b0, 1'b0, CUT_SLOT);
        stop_run(16, "run cleared mid-frame");
        run_frames(N_RESTART, 1'b0, 1'b0);

        $display("errors: pair %0d, lines %0d (%0d frames checked)",
                 pair_errs, line_errs, frames_checked);
        if (pair_errs + line_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
